/* common/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// program buffer size in words
`define PROG_DEPTH 16

// buffer pointer width, log2 of PROG_DEPTH
`define PTR_W 4

// register index width, x0 to x31
`define REG_W 5

// retire counter width
`define CNT_W 8

`endif

/* common/rv_pkg.sv */
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

	typedef logic [`REG_W-1:0] reg_idx_t;

	localparam reg_idx_t X0 = '0; // hardwired zero register

	// major opcode field, bits [6:0]
	typedef enum logic [6:0] {
		LOAD  = 7'b000_0011,
		MEM   = 7'b000_1111, // misc-mem, fence
		I     = 7'b001_0011,
		STORE = 7'b010_0011,
		R     = 7'b011_0011,
		LUI   = 7'b011_0111,
		B     = 7'b110_0011,
		JALR  = 7'b110_0111,
		JAL   = 7'b110_1111
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_view_t;

	// store and branch layout, immediate split around the sources
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} s_view_t;

	typedef union packed {
		r_view_t r;
		s_view_t s;
	} instr_t;

	typedef enum logic [1:0] {
		RS_SEL,
		EX_EX_FWD_SEL,
		MEM_EX_FWD_SEL,
		MEM_MEM_FWD_SEL
	} fwd_sel_t;

	// decode-stage branch operand source
	typedef enum logic [1:0] {
		B_RS_SEL,
		B_EX_SEL,
		B_MEM_SEL,
		B_WB_SEL
	} branch_fwd_t;

	// opcodes that write a destination register
	function automatic logic writes_rd(opcode_t op);
		case (op)
			LOAD, I, R, LUI, JAL, JALR: writes_rd = 1'b1;
			default:                    writes_rd = 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hdl/prog_loader_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_loader_fsm (
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	input  logic last_in,
	input  logic prog_end,
	input  logic pipe_empty,
	output logic ack,
	output logic wr_en,
	output logic issue_en,
	output logic done,
	output logic load_start
);

	typedef enum logic [2:0] {
		LOAD_WAIT,
		LOAD_ACK,
		RUN,
		DRAIN,
		DONE
	} state_t;

	state_t state, state_nxt;
	logic   last_q; // word being acked closes the program

	always_comb begin
		state_nxt = state;
		case (state)
			LOAD_WAIT: if (req) state_nxt = LOAD_ACK;
			LOAD_ACK: begin
				if (!req)
					state_nxt = last_q ? RUN : LOAD_WAIT;
			end
			RUN:       if (prog_end) state_nxt = DRAIN;
			DRAIN:     if (pipe_empty) state_nxt = DONE;
			DONE:      if (req) state_nxt = LOAD_ACK; // first word of next program
			default:   state_nxt = LOAD_WAIT;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= LOAD_WAIT;
			last_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (wr_en)
				last_q <= last_in;
		end
	end

	// one write per handshake, on the edge that raises ack
	assign wr_en      = req && ((state == LOAD_WAIT) || (state == DONE));
	assign load_start = req && (state == DONE);
	assign ack        = (state == LOAD_ACK);

	// stop issuing once the read pointer reaches the write pointer
	assign issue_en = (state == RUN) && !prog_end;
	assign done     = (state == DONE);

endmodule

`default_nettype wire

/* hdl/issue_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module issue_counter (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              load_start,
	input  logic              wr_en,
	input  logic              issue_en,
	input  logic              stall_if_id,
	output logic [`PTR_W-1:0] wr_ptr,
	output logic [`PTR_W-1:0] rd_ptr,
	output logic              prog_end
);

	logic [`PTR_W-1:0] wr_cnt; // words loaded so far

	// a new load writes its first word at zero in the same cycle
	assign wr_ptr = load_start ? '0 : wr_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_cnt <= wr_ptr + 1'b1;
			if (load_start)
				rd_ptr <= '0;
			else if (issue_en && !stall_if_id)
				rd_ptr <= rd_ptr + 1'b1; // F holds during a stall
		end
	end

	// programs up to PROG_DEPTH-1 words so the pointers only meet at the end
	assign prog_end = (rd_ptr == wr_cnt);

endmodule

`default_nettype wire

/* hdl/prog_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module prog_buffer import rv_pkg::*; (
	input  logic              clk,
	input  logic              wr_en,
	input  logic [`PTR_W-1:0] wr_ptr,
	input  logic [`PTR_W-1:0] rd_ptr,
	input  instr_t            instr_in,
	input  logic              taken_in,
	output instr_t            rd_instr,
	output logic              rd_taken
);

	instr_t words [`PROG_DEPTH];
	logic   taken [`PROG_DEPTH]; // branch outcome per word

	always_ff @(posedge clk) begin
		if (wr_en) begin
			words[wr_ptr] <= instr_in;
			taken[wr_ptr] <= taken_in;
		end
	end

	// read side feeds F directly
	assign rd_instr = words[rd_ptr];
	assign rd_taken = taken[rd_ptr];

endmodule

`default_nettype wire

/* hdl/stage_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module stage_regs import rv_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              issue_en,
	input  instr_t            rd_instr,
	input  logic              rd_taken,
	input  logic              stall_if_id,
	input  logic              stall_id_ex,
	input  logic              flush_if_id,
	output instr_t            instr_f,
	output instr_t            instr_d,
	output instr_t            instr_x,
	output instr_t            instr_m,
	output instr_t            instr_w,
	output logic              ex_mem_wr_rd,
	output logic              mem_wb_wr_rd,
	output logic              branch_actual,
	output logic [`CNT_W-1:0] retire_count,
	output logic              pipe_empty
);

	instr_t f_q, d_q, x_q, m_q, w_q;
	logic   f_taken, d_taken;
	logic   f_v, d_v, x_v, m_v, w_v;
	logic   issue_q; // issue_en last cycle, marks the start of a run

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			f_v     <= 1'b0;
			d_v     <= 1'b0;
			x_v     <= 1'b0;
			m_v     <= 1'b0;
			w_v     <= 1'b0;
			issue_q <= 1'b0;
		end else begin
			if (!stall_if_id) begin
				f_v <= issue_en;
				d_v <= f_v && !flush_if_id; // word behind a jump is dropped
			end
			x_v     <= d_v && !stall_id_ex;
			m_v     <= x_v;
			w_v     <= m_v;
			issue_q <= issue_en;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if_id) begin
			f_q     <= rd_instr;
			f_taken <= rd_taken;
			d_q     <= f_q;
			d_taken <= f_taken;
		end
		x_q <= d_q;
		m_q <= x_q;
		w_q <= m_q;
	end

	// counts words leaving W, restarts with each run
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			retire_count <= '0;
		else if (issue_en && !issue_q)
			retire_count <= '0;
		else if (w_v)
			retire_count <= retire_count + 1'b1;
	end

	// empty stages read as all zero
	assign instr_f = f_v ? f_q : '0;
	assign instr_d = d_v ? d_q : '0;
	assign instr_x = x_v ? x_q : '0;
	assign instr_m = m_v ? m_q : '0;
	assign instr_w = w_v ? w_q : '0;

	assign ex_mem_wr_rd  = m_v && writes_rd(m_q.r.opcode);
	assign mem_wb_wr_rd  = w_v && writes_rd(w_q.r.opcode);
	assign branch_actual = d_taken && (instr_d.r.opcode == B);
	assign pipe_empty    = !(f_v || d_v || x_v || m_v || w_v);

endmodule

`default_nettype wire

/* hazard/hazard_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl import rv_pkg::*; (
	input  instr_t      instr_f,
	input  instr_t      instr_d,
	input  instr_t      instr_x,
	input  instr_t      instr_m,
	input  instr_t      instr_w,
	input  logic        ex_mem_wr_rd,
	input  logic        mem_wb_wr_rd,
	input  logic        branch_actual,
	output fwd_sel_t    fwd_a,
	output fwd_sel_t    fwd_b,
	output fwd_sel_t    fwd_m2m,
	output branch_fwd_t fwd_rs1,
	output branch_fwd_t fwd_rs2,
	output logic        stall_if_id,
	output logic        stall_id_ex,
	output logic        flush_if_id
);

	function automatic logic uses_rs1(opcode_t op);
		case (op)
			JALR, B, LOAD, STORE, I, R, MEM: uses_rs1 = 1'b1;
			default:                         uses_rs1 = 1'b0;
		endcase
	endfunction

	function automatic logic uses_rs2(opcode_t op);
		case (op)
			R, STORE, B: uses_rs2 = 1'b1;
			default:     uses_rs2 = 1'b0;
		endcase
	endfunction

	reg_idx_t d_rs1, d_rs2, x_rs1, x_rs2, x_rd, m_rs2, m_rd, w_rd;
	logic     x_wr_rd, d_branch, x_load, m_load, m_store, jump, f_busy;
	logic     ex_a, ex_b, mem_a, mem_b, m2m;
	logic     ld_x_a, ld_x_b, ld_m_a, ld_m_b;
	logic     bx_a, bx_b, bm_a, bm_b, bw_a, bw_b;

	assign d_rs1 = instr_d.r.rs1;
	assign d_rs2 = instr_d.r.rs2;
	assign x_rs1 = instr_x.r.rs1;
	assign x_rs2 = instr_x.r.rs2;
	assign x_rd  = instr_x.r.rd;
	assign m_rs2 = instr_m.r.rs2;
	assign m_rd  = instr_m.r.rd;
	assign w_rd  = instr_w.r.rd;

	assign x_wr_rd  = writes_rd(instr_x.r.opcode); // bubbles carry opcode 0
	assign d_branch = (instr_d.r.opcode == B);
	assign x_load   = (instr_x.r.opcode == LOAD);
	assign m_load   = (instr_m.r.opcode == LOAD);
	assign m_store  = (instr_m.r.opcode == STORE);

	// execute operands, M result wins over W
	assign ex_a  = ex_mem_wr_rd && (m_rd != X0) && (m_rd == x_rs1) && uses_rs1(instr_x.r.opcode);
	assign ex_b  = ex_mem_wr_rd && (m_rd != X0) && (m_rd == x_rs2) && uses_rs2(instr_x.r.opcode);
	assign mem_a = mem_wb_wr_rd && (w_rd != X0) && (w_rd == x_rs1) && uses_rs1(instr_x.r.opcode)
		&& !ex_a;
	assign mem_b = mem_wb_wr_rd && (w_rd != X0) && (w_rd == x_rs2) && uses_rs2(instr_x.r.opcode)
		&& !ex_b;

	// store data in M taken straight from the word in W
	assign m2m = m_store && mem_wb_wr_rd && (w_rd != X0) && (w_rd == m_rs2);

	always_comb begin
		fwd_a   = ex_a ? EX_EX_FWD_SEL : (mem_a ? MEM_EX_FWD_SEL : RS_SEL);
		fwd_b   = ex_b ? EX_EX_FWD_SEL : (mem_b ? MEM_EX_FWD_SEL : RS_SEL);
		fwd_m2m = m2m ? MEM_MEM_FWD_SEL : RS_SEL;
	end

	// load data is not ready for a branch compare in D
	assign ld_x_a = d_branch && x_load && (x_rd != X0) && (x_rd == d_rs1);
	assign ld_x_b = d_branch && x_load && (x_rd != X0) && (x_rd == d_rs2);
	assign ld_m_a = d_branch && m_load && (m_rd != X0) && (m_rd == d_rs1);
	assign ld_m_b = d_branch && m_load && (m_rd != X0) && (m_rd == d_rs2);

	assign stall_if_id = ld_x_a || ld_x_b || ld_m_a || ld_m_b;
	assign stall_id_ex = stall_if_id; // bubble into X while D holds

	// branch operands, nearest producer first
	assign bx_a = x_wr_rd && (x_rd != X0) && (x_rd == d_rs1);
	assign bx_b = x_wr_rd && (x_rd != X0) && (x_rd == d_rs2);
	assign bm_a = ex_mem_wr_rd && (m_rd != X0) && (m_rd == d_rs1) && !bx_a;
	assign bm_b = ex_mem_wr_rd && (m_rd != X0) && (m_rd == d_rs2) && !bx_b;
	assign bw_a = mem_wb_wr_rd && (w_rd != X0) && (w_rd == d_rs1) && !bx_a && !bm_a;
	assign bw_b = mem_wb_wr_rd && (w_rd != X0) && (w_rd == d_rs2) && !bx_b && !bm_b;

	always_comb begin
		fwd_rs1 = B_RS_SEL;
		fwd_rs2 = B_RS_SEL;
		if (d_branch && !stall_if_id) begin
			if (bx_a)
				fwd_rs1 = B_EX_SEL;
			else if (bm_a)
				fwd_rs1 = B_MEM_SEL;
			else if (bw_a)
				fwd_rs1 = B_WB_SEL;
			if (bx_b)
				fwd_rs2 = B_EX_SEL;
			else if (bm_b)
				fwd_rs2 = B_MEM_SEL;
			else if (bw_b)
				fwd_rs2 = B_WB_SEL;
		end
	end

	assign jump   = (instr_d.r.opcode == JAL) || (instr_d.r.opcode == JALR);
	assign f_busy = (instr_f != '0); // a word sits behind D

	// a stalled branch has not resolved yet
	assign flush_if_id = (jump || branch_actual) && f_busy && !stall_if_id;

endmodule

`default_nettype wire

/* hdl/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module pipe_ctrl_top import rv_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  instr_t            instr_in,
	input  logic              taken_in,
	input  logic              last_in,
	output logic              ack,
	output fwd_sel_t          fwd_a,
	output fwd_sel_t          fwd_b,
	output fwd_sel_t          fwd_m2m,
	output branch_fwd_t       fwd_rs1,
	output branch_fwd_t       fwd_rs2,
	output logic              stall_if_id,
	output logic              flush_if_id,
	output logic [`CNT_W-1:0] retire_count,
	output logic              done
);

	logic              wr_en, issue_en, load_start, prog_end, pipe_empty;
	logic [`PTR_W-1:0] wr_ptr, rd_ptr;
	instr_t            rd_instr;
	logic              rd_taken;
	instr_t            instr_f, instr_d, instr_x, instr_m, instr_w;
	logic              ex_mem_wr_rd, mem_wb_wr_rd, branch_actual, stall_id_ex;

	prog_loader_fsm u_fsm (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.last_in    (last_in),
		.prog_end   (prog_end),
		.pipe_empty (pipe_empty),
		.ack        (ack),
		.wr_en      (wr_en),
		.issue_en   (issue_en),
		.done       (done),
		.load_start (load_start)
	);

	issue_counter u_cnt (
		.clk         (clk),
		.arst_n      (arst_n),
		.load_start  (load_start),
		.wr_en       (wr_en),
		.issue_en    (issue_en),
		.stall_if_id (stall_if_id),
		.wr_ptr      (wr_ptr),
		.rd_ptr      (rd_ptr),
		.prog_end    (prog_end)
	);

	prog_buffer u_buf (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_ptr   (wr_ptr),
		.rd_ptr   (rd_ptr),
		.instr_in (instr_in),
		.taken_in (taken_in),
		.rd_instr (rd_instr),
		.rd_taken (rd_taken)
	);

	stage_regs u_stages (
		.clk           (clk),
		.arst_n        (arst_n),
		.issue_en      (issue_en),
		.rd_instr      (rd_instr),
		.rd_taken      (rd_taken),
		.stall_if_id   (stall_if_id),
		.stall_id_ex   (stall_id_ex),
		.flush_if_id   (flush_if_id),
		.instr_f       (instr_f),
		.instr_d       (instr_d),
		.instr_x       (instr_x),
		.instr_m       (instr_m),
		.instr_w       (instr_w),
		.ex_mem_wr_rd  (ex_mem_wr_rd),
		.mem_wb_wr_rd  (mem_wb_wr_rd),
		.branch_actual (branch_actual),
		.retire_count  (retire_count),
		.pipe_empty    (pipe_empty)
	);

	hazard_ctrl u_hazard (
		.instr_f       (instr_f),
		.instr_d       (instr_d),
		.instr_x       (instr_x),
		.instr_m       (instr_m),
		.instr_w       (instr_w),
		.ex_mem_wr_rd  (ex_mem_wr_rd),
		.mem_wb_wr_rd  (mem_wb_wr_rd),
		.branch_actual (branch_actual),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.fwd_m2m       (fwd_m2m),
		.fwd_rs1       (fwd_rs1),
		.fwd_rs2       (fwd_rs2),
		.stall_if_id   (stall_if_id),
		.stall_id_ex   (stall_id_ex),
		.flush_if_id   (flush_if_id)
	);

endmodule

`default_nettype wire

/* dv/pipe_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_properties import rv_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     req,
	input logic     ack,
	input logic     issue_en,
	input logic     stall_if_id,
	input logic     flush_if_id,
	input fwd_sel_t fwd_a,
	input fwd_sel_t fwd_b,
	input fwd_sel_t fwd_m2m,
	input instr_t   instr_d,
	input instr_t   instr_x,
	input instr_t   instr_m
);

	int   err_count; // read by the testbench after each program
	logic run_seen;  // set by the first issue after reset

	initial err_count = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			run_seen <= 1'b0;
		else if (issue_en)
			run_seen <= 1'b1;
	end

	// four-phase port
	ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else begin
			err_count++;
			$error("ack rose without a request");
		end

	ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(ack) |-> !$past(req))
		else begin
			err_count++;
			$error("ack fell while req was still high");
		end

	req_answered: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(req) |=> $rose(ack))
		else begin
			err_count++;
			$error("a request did not raise ack one cycle later");
		end

	ack_release: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(req) |=> !ack)
		else begin
			err_count++;
			$error("ack stayed high after the request dropped");
		end

	// D is held while IF/ID stalls
	stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		stall_if_id |=> $stable(instr_d))
		else begin
			err_count++;
			$error("D stage changed during a stall");
		end

	// x0 is never a forwarding source
	x0_a: assert property (@(posedge clk) disable iff (!arst_n)
		fwd_a != RS_SEL |-> instr_x.r.rs1 != X0)
		else begin
			err_count++;
			$error("operand a forwarded for x0");
		end

	x0_b: assert property (@(posedge clk) disable iff (!arst_n)
		fwd_b != RS_SEL |-> instr_x.r.rs2 != X0)
		else begin
			err_count++;
			$error("operand b forwarded for x0");
		end

	x0_m2m: assert property (@(posedge clk) disable iff (!arst_n)
		fwd_m2m != RS_SEL |-> instr_m.s.rs2 != X0)
		else begin
			err_count++;
			$error("store data forwarded for x0");
		end

	quiet_before_run: assert property (@(posedge clk) disable iff (!arst_n)
		!run_seen |-> !stall_if_id && !flush_if_id)
		else begin
			err_count++;
			$error("stall or flush before the first run");
		end

endmodule

bind pipe_ctrl_top pipe_ctrl_properties u_props (
	.clk         (clk),
	.arst_n      (arst_n),
	.req         (req),
	.ack         (ack),
	.issue_en    (issue_en),
	.stall_if_id (stall_if_id),
	.flush_if_id (flush_if_id),
	.fwd_a       (fwd_a),
	.fwd_b       (fwd_b),
	.fwd_m2m     (fwd_m2m),
	.instr_d     (instr_d),
	.instr_x     (instr_x),
	.instr_m     (instr_m)
);

`default_nettype wire

/* dv/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module pipe_ctrl_tb import rv_pkg::*; ();

	localparam int ACK_LIMIT  = 20;
	localparam int DONE_LIMIT = 300;

	logic              clk, arst_n, req, taken_in, last_in, ack, done;
	instr_t            instr_in;
	fwd_sel_t          fwd_a, fwd_b, fwd_m2m;
	branch_fwd_t       fwd_rs1, fwd_rs2;
	logic              stall_if_id, flush_if_id;
	logic [`CNT_W-1:0] retire_count;

	instr_t      prog[$];
	logic        taken_q[$];
	logic [31:0] rng;
	logic        ack_prev;
	int          n_ack, n_ex, n_mem, n_exb, n_memb, n_m2m, n_stall, n_flush, n_bwb;
	int          test_errs, n_pass, n_fail;

	pipe_ctrl_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// cycle counts of each select, sampled mid-cycle
	always @(negedge clk) begin
		if (arst_n) begin
			if (fwd_a == EX_EX_FWD_SEL)
				n_ex++;
			if (fwd_a == MEM_EX_FWD_SEL)
				n_mem++;
			if (fwd_b == EX_EX_FWD_SEL)
				n_exb++;
			if (fwd_b == MEM_EX_FWD_SEL)
				n_memb++;
			if (fwd_m2m == MEM_MEM_FWD_SEL)
				n_m2m++;
			if (stall_if_id)
				n_stall++;
			if (flush_if_id)
				n_flush++;
			if (fwd_rs1 == B_WB_SEL || fwd_rs2 == B_WB_SEL)
				n_bwb++;
			if (ack && !ack_prev)
				n_ack++;
		end
		ack_prev = ack;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// fillers read x24..x31 and write x16..x23, so they never meet a chain
	function automatic reg_idx_t filler_src();
		rng = xorshift32(rng);
		return 5'd24 + rng[2:0];
	endfunction

	function automatic reg_idx_t filler_dst();
		rng = xorshift32(rng);
		return 5'd16 + rng[2:0];
	endfunction

	function automatic instr_t r_word(opcode_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		instr_t w;
		w = '0;
		w.r.opcode = op;
		w.r.rd     = rd;
		w.r.rs1    = rs1;
		w.r.rs2    = rs2;
		return w;
	endfunction

	function automatic instr_t s_word(opcode_t op, reg_idx_t rs1, reg_idx_t rs2);
		instr_t w;
		w = '0;
		w.s.opcode = op;
		w.s.rs1    = rs1;
		w.s.rs2    = rs2;
		w.s.imm_lo = 5'h4; // small offset
		return w;
	endfunction

	function automatic instr_t filler_word();
		return r_word(R, filler_dst(), filler_src(), filler_src());
	endfunction

	task automatic push_word(input instr_t w, input logic taken);
		prog.push_back(w);
		taken_q.push_back(taken);
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (ack !== level) begin
			if (n == ACK_LIMIT)
				report_timeout(what);
			@(posedge clk);
			#2;
			n++;
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (done !== 1'b1) begin
			if (n == DONE_LIMIT)
				report_timeout("done never rose after the program was loaded");
			@(posedge clk);
			#2;
			n++;
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			wait_ack(1'b0, "ack stayed high before a new word");
			instr_in = prog[i];
			taken_in = taken_q[i];
			last_in  = (i == prog.size() - 1);
			req      = 1'b1;
			wait_ack(1'b1, "ack did not answer a request");
			req = 1'b0;
			wait_ack(1'b0, "ack did not drop after the request");
		end
	endtask

	task automatic clear_counts();
		n_ack   = 0;
		n_ex    = 0;
		n_mem   = 0;
		n_exb   = 0;
		n_memb  = 0;
		n_m2m   = 0;
		n_stall = 0;
		n_flush = 0;
		n_bwb   = 0;
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic run_test(input string name, input int exp_retire, input int exp_ex,
			input int exp_mem, input int exp_exb, input int exp_memb, input int exp_m2m,
			input int exp_stall, input int exp_flush, input int exp_bwb);
		int asrt0;
		test_errs = 0;
		asrt0 = dut.u_props.err_count;
		clear_counts();
		load_program();
		wait_done();
		check_count("acks", n_ack, prog.size());
		check_count("retire_count", retire_count, exp_retire);
		check_count("EX-EX cycles on fwd_a", n_ex, exp_ex);
		check_count("MEM-EX cycles on fwd_a", n_mem, exp_mem);
		check_count("EX-EX cycles on fwd_b", n_exb, exp_exb);
		check_count("MEM-EX cycles on fwd_b", n_memb, exp_memb);
		check_count("store forward cycles", n_m2m, exp_m2m);
		check_count("stall cycles", n_stall, exp_stall);
		check_count("flush cycles", n_flush, exp_flush);
		check_count("branch WB forward cycles", n_bwb, exp_bwb);
		if (dut.u_props.err_count != asrt0) begin
			$display("assertions failed during %s", name);
			test_errs++;
		end
		if (test_errs == 0)
			n_pass++;
		else
			n_fail++;
		$display("%-12s %s  retire %0d/%0d ex %0d/%0d mem %0d/%0d m2m %0d stall %0d flush %0d bwb %0d",
			name, (test_errs == 0) ? "pass" : "FAIL", retire_count, exp_retire,
			n_ex, n_exb, n_mem, n_memb, n_m2m, n_stall, n_flush, n_bwb);
		prog.delete();
		taken_q.delete();
	endtask

	initial begin
		req      = 1'b0;
		instr_in = '0;
		taken_in = 1'b0;
		last_in  = 1'b0;
		arst_n   = 1'b0;
		ack_prev = 1'b0;
		rng      = 32'hfe4b_137d;
		n_pass   = 0;
		n_fail   = 0;
		clear_counts();
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;

		repeat (6) push_word(filler_word(), 1'b0);
		run_test("handshake", 6, 0, 0, 0, 0, 0, 0, 0, 0);

		// x5 read by the next word and the one after it
		push_word(r_word(R, 5'd5, filler_src(), filler_src()), 1'b0);
		push_word(r_word(R, 5'd6, 5'd5, filler_src()), 1'b0);
		push_word(r_word(R, 5'd9, 5'd5, 5'd5), 1'b0);
		push_word(filler_word(), 1'b0);
		run_test("alu_chain", 4, 1, 1, 0, 1, 0, 0, 0, 0);

		// store data sees the load in M, then takes it from W
		push_word(r_word(LOAD, 5'd7, filler_src(), 5'd0), 1'b0);
		push_word(s_word(STORE, filler_src(), 5'd7), 1'b0);
		push_word(filler_word(), 1'b0);
		run_test("store_fwd", 3, 0, 0, 1, 0, 1, 0, 0, 0);

		// branch compare waits for the load, then takes it from W
		push_word(r_word(LOAD, 5'd8, filler_src(), 5'd0), 1'b0);
		push_word(s_word(B, 5'd8, filler_src()), 1'b0);
		push_word(filler_word(), 1'b0);
		push_word(filler_word(), 1'b0);
		run_test("load_branch", 4, 0, 0, 0, 0, 0, 2, 0, 1);

		push_word(r_word(JAL, 5'd1, 5'd0, 5'd0), 1'b0);
		push_word(filler_word(), 1'b0); // dropped
		push_word(s_word(B, filler_src(), filler_src()), 1'b1);
		push_word(filler_word(), 1'b0); // dropped
		push_word(filler_word(), 1'b0);
		run_test("jump_flush", 3, 0, 0, 0, 0, 0, 0, 2, 0);

		push_word(r_word(R, 5'd0, filler_src(), filler_src()), 1'b0);
		push_word(r_word(R, 5'd10, 5'd0, filler_src()), 1'b0);
		push_word(r_word(R, 5'd10, filler_src(), filler_src()), 1'b0);
		push_word(r_word(R, 5'd10, filler_src(), filler_src()), 1'b0);
		push_word(r_word(R, 5'd11, 5'd10, filler_src()), 1'b0); // M and W both hold x10
		push_word(r_word(LOAD, 5'd0, filler_src(), 5'd0), 1'b0);
		push_word(s_word(STORE, filler_src(), 5'd0), 1'b0);
		push_word(r_word(LOAD, 5'd0, filler_src(), 5'd0), 1'b0);
		push_word(s_word(B, 5'd0, 5'd0), 1'b0);
		push_word(filler_word(), 1'b0);
		run_test("x0_priority", 10, 1, 0, 0, 0, 0, 0, 0, 0);

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* pipe_ctrl_top.f */
+incdir+common
common/rv_pkg.sv
hdl/prog_loader_fsm.sv
hdl/issue_counter.sv
hdl/prog_buffer.sv
hdl/stage_regs.sv
hazard/hazard_ctrl.sv
hdl/pipe_ctrl_top.sv
dv/pipe_ctrl_properties.sv
dv/pipe_ctrl_tb.sv
